// File: Bender.yml
package:
  name: alureg

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - inst_decode.sv
  - alu8.sv
  - reg_bank.sv
  - alureg.sv
  - target: test
    files:
      - alureg_tb.sv

// File: alu8.sv
`timescale 1ns/10ps
`default_nettype none

module alu8 (
	input cpu_pkg::alu_op_t i_op, // opcode bits 5..3
	input cpu_pkg::data_t i_op1, // accumulator
	input cpu_pkg::data_t i_op2, // source register or temp
	input cpu_pkg::flags_t i_flags, // current F
	output cpu_pkg::data_t o_res,
	output cpu_pkg::flags_t o_flags
);
	import cpu_pkg::*;

	localparam alu_op_t OP_ADD = 3'b000;
	localparam alu_op_t OP_ADC = 3'b001;
	localparam alu_op_t OP_SUB = 3'b010;
	localparam alu_op_t OP_SBB = 3'b011;
	localparam alu_op_t OP_ANA = 3'b100;
	localparam alu_op_t OP_XRA = 3'b101;
	localparam alu_op_t OP_ORA = 3'b110;
	localparam alu_op_t OP_CMP = 3'b111;

	logic cin; // carry in for adc / borrow in for sbb
	logic [8:0] wide; // result with carry out
	logic [4:0] nib; // low nibble with carry out
	data_t calc; // value the flags are taken from
	logic cy, ac;

	assign cin = i_flags.c & i_op[0] & ~i_op[2]; // adc, sbb only

	always_comb begin
		wide = '0;
		nib = '0;
		ac = 1'b0;
		case (i_op)
			OP_ADD, OP_ADC: begin
				wide = {1'b0, i_op1} + {1'b0, i_op2} + {8'd0, cin};
				nib = {1'b0, i_op1[3:0]} + {1'b0, i_op2[3:0]} + {4'd0, cin};
				ac = nib[4]; // carry out of bit 3
			end
			OP_SUB, OP_SBB, OP_CMP: begin
				wide = {1'b0, i_op1} - {1'b0, i_op2} - {8'd0, cin};
				nib = {1'b0, i_op1[3:0]} - {1'b0, i_op2[3:0]} - {4'd0, cin};
				ac = nib[4]; // borrow out of bit 3
			end
			OP_ANA: begin
				wide = {1'b0, i_op1 & i_op2};
				ac = i_op1[3] | i_op2[3]; // 8085 style and
			end
			OP_XRA: wide = {1'b0, i_op1 ^ i_op2};
			OP_ORA: wide = {1'b0, i_op1 | i_op2};
			default: wide = {1'b0, i_op1};
		endcase
		calc = wide[7:0];
		cy = wide[8]; // logic ops leave bit 8 clear
	end

	assign o_res = (i_op == OP_CMP) ? i_op1 : calc; // cmp keeps A

	always_comb begin
		o_flags = '0; // unused bits stay low
		o_flags.s = calc[7];
		o_flags.z = (calc == 8'd0);
		o_flags.a = ac;
		o_flags.p = ~^calc; // even parity
		o_flags.c = cy;
	end

endmodule

`default_nettype wire

// File: alureg.sv
`timescale 1ns/10ps
`default_nettype none

module alureg (
	input logic clk,
	input logic i_rst_n,
	input logic i_enb_c, // latch instruction
	input logic i_enb_d, // latch data into temp
	input logic i_enbpc, // advance pc
	input logic i_enb_r, // read port enable
	input logic i_enb_w, // write back
	input cpu_pkg::data_t i_bus_d,
	output cpu_pkg::inst_info_t o_inst_info,
	output cpu_pkg::addr_t o_pc,
	output cpu_pkg::data_t o_rd_data
);
	import cpu_pkg::*;

	data_t opcode, op1, op2, alu_res;
	flags_t cur_flags, alu_flags;
	inst_info_t dec_info; // cond still 0 here

	inst_decode u_decode (
		.i_opcode (opcode),
		.o_info (dec_info)
	);

	alu8 u_alu (
		.i_op (alu_op_t'(opcode[5:3])), // operation field
		.i_op1 (op1),
		.i_op2 (op2),
		.i_flags (cur_flags),
		.o_res (alu_res),
		.o_flags (alu_flags)
	);

	reg_bank u_regs (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_enb_c (i_enb_c),
		.i_enb_d (i_enb_d),
		.i_enbpc (i_enbpc),
		.i_enb_r (i_enb_r),
		.i_enb_w (i_enb_w),
		.i_bus_d (i_bus_d),
		.i_alu_res (alu_res),
		.i_alu_flags (alu_flags),
		.i_info (dec_info),
		.o_opcode (opcode),
		.o_op1 (op1),
		.o_op2 (op2),
		.o_flags (cur_flags),
		.o_inst_info (o_inst_info),
		.o_pc (o_pc),
		.o_rd_data (o_rd_data)
	);

endmodule

`default_nettype wire

// File: alureg_tb.sv
`timescale 1ns/10ps
`include "cpu_params.svh"
`default_nettype none

module alureg_tb;
	import cpu_pkg::*;

	localparam integer SWEEP_CYCLES = 65536; // pc run up to ffff
	localparam integer MAX_CYCLES = SWEEP_CYCLES + 3000; // sweep plus the short tests

	logic clk;
	logic i_rst_n;
	logic i_enb_c, i_enb_d, i_enbpc, i_enb_r, i_enb_w;
	data_t i_bus_d;
	inst_info_t o_inst_info;
	addr_t o_pc;
	data_t o_rd_data;

	data_t m_regs [8]; // model of B C D E H L F A
	data_t m_temp, m_inst; // model latches
	addr_t m_pc;
	integer seed;
	integer errors, checks, cycles;
	integer test_errors, test_checks; // counts when the current test began

	alureg uut (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_enb_c (i_enb_c),
		.i_enb_d (i_enb_d),
		.i_enbpc (i_enbpc),
		.i_enb_r (i_enb_r),
		.i_enb_w (i_enb_w),
		.i_bus_d (i_bus_d),
		.o_inst_info (o_inst_info),
		.o_pc (o_pc),
		.o_rd_data (o_rd_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// pc moves by one per strobe, holds otherwise
	pc_step: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_pc == $past(o_pc) + {15'd0, $past(i_enbpc)})
		else begin
			$display("Fail o_pc step: got %h, expected %h", $sampled(o_pc),
				$past(o_pc) + {15'd0, $past(i_enbpc)});
			errors = errors + 1;
		end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks = checks + 1;
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic end_test(input integer num, input string name);
		$display("test %0d %s: %0d checks, %0d errors", num, name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	function automatic logic cond_model(input logic [2:0] ccc, input data_t f);
		logic flag;
		case (ccc[2:1])
			2'd0: flag = f[`FLAGBIT_Z]; // nz / z
			2'd1: flag = f[`FLAGBIT_C]; // nc / c
			2'd2: flag = f[`FLAGBIT_P]; // po / pe
			default: flag = f[`FLAGBIT_S]; // p / m
		endcase
		return ccc[0] ? flag : ~flag;
	endfunction

	// result in the upper byte, flags in the lower byte
	function automatic logic [15:0] alu_model(input alu_op_t op, input data_t a,
		input data_t b, input logic cy_in);
		integer full, low, ones;
		logic cin;
		data_t val, f;
		cin = (op == 3'd1 || op == 3'd3) ? cy_in : 1'b0; // adc, sbb
		f = '0;
		low = 0;
		ones = 0;
		case (op)
			3'd0, 3'd1: begin
				full = int'(a) + int'(b) + int'(cin);
				low = int'(a[3:0]) + int'(b[3:0]) + int'(cin);
				f[`FLAGBIT_C] = (full > 255);
				f[`FLAGBIT_A] = (low > 15); // nibble carry
			end
			3'd4: begin
				full = int'(a & b);
				f[`FLAGBIT_A] = a[3] | b[3];
			end
			3'd5: full = int'(a ^ b);
			3'd6: full = int'(a | b);
			default: begin // sub, sbb, cmp
				full = int'(a) - int'(b) - int'(cin);
				low = int'(a[3:0]) - int'(b[3:0]) - int'(cin);
				f[`FLAGBIT_C] = (full < 0); // borrow
				f[`FLAGBIT_A] = (low < 0);
			end
		endcase
		val = data_t'(full);
		for (int k = 0; k < 8; k++) ones = ones + val[k];
		f[`FLAGBIT_S] = val[7];
		f[`FLAGBIT_Z] = (val == 8'd0);
		f[`FLAGBIT_P] = (ones % 2 == 0); // even parity
		return {(op == 3'd7) ? a : val, f & `FLAG_MASK};
	endfunction

	// 8085 machine cycle table, rw bit 0 is cycle 2
	function automatic inst_info_t decode_model(input data_t op, input data_t f);
		integer n;
		inst_info_t e;
		e = '0;
		n = 1;
		casez (op)
			8'b01110110: begin // hlt
				n = 2;
				e.hlt = 1'b1;
			end
			8'b01110???: begin // mov M,r
				n = 2;
				e.cyc_rw = 4'b0001;
			end
			8'b01???110: n = 2; // mov r,M
			8'b10???110: n = 2; // alu M
			8'b00110110, 8'b0011010?: begin // mvi/inr/dcr M
				n = 3;
				e.cyc_rw = 4'b0010;
			end
			8'b00???110: n = 2; // mvi r
			8'b00??0001: n = 3; // lxi
			8'b00??1001: begin // dad
				n = 3;
				e.dad = 1'b1;
			end
			8'b000?0010: begin // stax
				n = 2;
				e.cyc_rw = 4'b0001;
			end
			8'b000?1010: n = 2; // ldax
			8'b00100010: begin // shld
				n = 5;
				e.cyc_rw = 4'b1100;
			end
			8'b00101010: n = 5; // lhld
			8'b00110010: begin // sta
				n = 4;
				e.cyc_rw = 4'b0100;
			end
			8'b00111010: n = 4; // lda
			8'b00???011: e.go6 = 1'b1; // inx, dcx
			8'b11???000: begin // rccc
				n = 3;
				e.go6 = 1'b1;
			end
			8'b11???010: n = 3; // jccc
			8'b11???100, 8'b11001101: begin // cccc, call
				n = 5;
				e.cyc_rw = 4'b1100;
				e.go6 = 1'b1;
			end
			8'b11???110: n = 2; // alu immediate
			8'b11???111, 8'b11??0101: begin // rst, push
				n = 3;
				e.cyc_rw = 4'b0011;
				e.go6 = 1'b1;
			end
			8'b11??0001, 8'b11000011, 8'b11001001: n = 3; // pop, jmp, ret
			8'b11010011: begin // out
				n = 3;
				e.cyc_rw = 4'b0010;
				e.dio = 1'b1;
			end
			8'b11011011: begin // in
				n = 3;
				e.dio = 1'b1;
			end
			8'b11100011: begin // xthl
				n = 5;
				e.cyc_rw = 4'b1100;
			end
			8'b11101001, 8'b11111001: e.go6 = 1'b1; // pchl, sphl
			default: n = 1;
		endcase
		case (n)
			2: e.cyc_go = 4'b0001;
			3: e.cyc_go = 4'b0011;
			4: e.cyc_go = 4'b0111;
			5: e.cyc_go = 4'b1111;
			default: e.cyc_go = 4'b0000;
		endcase
		e.cond = cond_model(op[5:3], f);
		return e;
	endfunction

	task automatic latch_opcode(input data_t op);
		i_bus_d = op;
		i_enb_c = 1'b1;
		@(negedge clk);
		i_enb_c = 1'b0;
		m_inst = op;
	endtask

	task automatic latch_temp(input data_t v);
		i_bus_d = v;
		i_enb_d = 1'b1;
		@(negedge clk);
		i_enb_d = 1'b0;
		m_temp = v;
	endtask

	task automatic write_back();
		data_t src_v;
		logic [15:0] rf;
		i_enb_w = 1'b1;
		@(negedge clk);
		i_enb_w = 1'b0;
		src_v = (m_inst[2:0] == 3'b110) ? m_temp : m_regs[m_inst[2:0]];
		if (m_inst[7:6] == 2'b10) begin
			rf = alu_model(m_inst[5:3], m_regs[`REG_A], src_v,
				m_regs[`REG_F][`FLAGBIT_C]);
			m_regs[`REG_A] = rf[15:8];
			m_regs[`REG_F] = rf[7:0];
		end else if (m_inst[7:6] == 2'b01 && m_inst[5:3] != 3'b110) begin
			m_regs[m_inst[5:3]] = src_v; // mov r,r or mov r,M
		end
	endtask

	task automatic load_reg(input reg_sel_t r, input data_t v);
		latch_opcode({2'b01, r, 3'b110}); // mov r,M
		latch_temp(v);
		write_back();
	endtask

	task automatic verify_read(input reg_sel_t r);
		latch_opcode({5'b01000, r}); // read port follows bits 2..0
		i_enb_r = 1'b1;
		#2;
		check_value($sformatf("o_rd_data(reg %0d)", r), o_rd_data, m_regs[r]);
		@(negedge clk);
		i_enb_r = 1'b0;
	endtask

	task automatic pulse_pc();
		i_enbpc = 1'b1;
		@(negedge clk);
		i_enbpc = 1'b0;
		m_pc = m_pc + 16'd1;
	endtask

	task automatic pick_reg(output reg_sel_t r);
		r = reg_sel_t'($random(seed));
		if (r == `REG_F) r = `REG_A; // F is not a mov target
	endtask

	task automatic run_alu(input alu_op_t op, input reg_sel_t src, input logic same);
		data_t a, b;
		a = data_t'($random(seed));
		b = same ? a : data_t'($random(seed));
		load_reg(`REG_A, a);
		if (src == 3'b110) latch_temp(b); // source M
		else if (src != `REG_A) load_reg(src, b);
		latch_opcode({2'b10, op, src});
		write_back();
	endtask

	initial begin
		reg_sel_t d, s;
		seed = 47873;
		errors = 0;
		checks = 0;
		cycles = 0;
		test_errors = 0;
		test_checks = 0;
		i_rst_n = 1'b0;
		i_enb_c = 1'b0;
		i_enb_d = 1'b0;
		i_enbpc = 1'b0;
		i_enb_r = 1'b0;
		i_enb_w = 1'b0;
		i_bus_d = '0;
		m_pc = '0;
		m_temp = '0;
		m_inst = '0;
		m_regs[`REG_F] = '0; // F is cleared by reset
		repeat (3) @(negedge clk);
		i_rst_n = 1'b1;

		check_value("o_pc", o_pc, m_pc);
		for (int i = 0; i < 6; i++) begin
			pulse_pc();
			check_value("o_pc", o_pc, m_pc);
			@(negedge clk); // idle cycle, pc holds
			check_value("o_pc", o_pc, m_pc);
		end
		i_enbpc = 1'b1;
		repeat (32'hffff - m_pc) @(negedge clk); // step rule checked each edge
		i_enbpc = 1'b0;
		m_pc = 16'hffff;
		check_value("o_pc", o_pc, m_pc);
		pulse_pc(); // wraps to 0000
		check_value("o_pc", o_pc, m_pc);
		end_test(1, "reset and pc");

		for (int r = 0; r < 8; r++) begin
			if (r != `REG_F) load_reg(reg_sel_t'(r), data_t'($random(seed)));
		end
		for (int r = 0; r < 8; r++) begin
			if (r != `REG_F) verify_read(reg_sel_t'(r));
		end
		end_test(2, "mov r,M load");

		for (int i = 0; i < 20; i++) begin
			pick_reg(d);
			pick_reg(s);
			latch_opcode({2'b01, d, s});
			write_back();
			check_value("o_rd_data(idle)", o_rd_data, 8'h00); // i_enb_r low
			verify_read(d);
		end
		end_test(3, "register moves");

		for (int i = 0; i < 32; i++) begin
			run_alu(alu_op_t'(i % 8), reg_sel_t'($random(seed)), 1'b0);
			verify_read(`REG_A);
			verify_read(`REG_F);
		end
		end_test(4, "alu operations");

		for (int op = 0; op < 256; op++) begin
			latch_opcode(data_t'(op));
			check_value($sformatf("o_inst_info(op %h)", op[7:0]), o_inst_info,
				decode_model(data_t'(op), m_regs[`REG_F]));
		end
		end_test(5, "decode table");

		for (int i = 0; i < 12; i++) begin
			run_alu(alu_op_t'($random(seed)), reg_sel_t'($random(seed)), (i % 2) == 0);
			for (int c = 0; c < 8; c++) begin
				latch_opcode({2'b11, c[2:0], 3'b010}); // jccc
				check_value($sformatf("o_inst_info.cond(ccc %0d)", c), o_inst_info.cond,
					cond_model(c[2:0], m_regs[`REG_F]));
			end
		end
		end_test(6, "conditions");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// register codes as found in opcode fields
`define REG_B 3'd0
`define REG_C 3'd1
`define REG_D 3'd2
`define REG_E 3'd3
`define REG_H 3'd4
`define REG_L 3'd5
`define REG_F 3'd6 // flags, code 110 means M in src/dst fields
`define REG_A 3'd7

// bit positions inside F
`define FLAGBIT_S 7
`define FLAGBIT_Z 6
`define FLAGBIT_A 4
`define FLAGBIT_P 2
`define FLAGBIT_C 0

// unused F bits forced to zero
`define FLAG_MASK 8'b1101_0101

`endif

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] data_t; // data bus byte
	typedef logic [15:0] addr_t; // address / pc
	typedef logic [2:0] reg_sel_t; // register code
	typedef logic [2:0] alu_op_t; // opcode bits 5..3 in alu group
	typedef logic [3:0] cyc_mask_t; // one bit per extra machine cycle

	// F register layout, msb first
	typedef struct packed {
		logic s; // sign
		logic z; // zero
		logic rsv5; // always 0
		logic a; // aux carry
		logic rsv3; // always 0
		logic p; // even parity
		logic rsv1; // always 0 after mask
		logic c; // carry / borrow
	} flags_t;

	// decoded info for the sequencer, bit 0 is go6
	typedef struct packed {
		logic cond; // condition met
		cyc_mask_t cyc_rw; // write cycles 2..5
		cyc_mask_t cyc_go; // thermometer, extra cycles 2..5
		logic dio; // in / out
		logic hlt; // halt
		logic dad; // double add
		logic go6; // six-state opcode fetch
	} inst_info_t;

endpackage

`default_nettype wire

// File: inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
	input cpu_pkg::data_t i_opcode, // latched instruction
	output cpu_pkg::inst_info_t o_info // decoded fields, cond left 0
);
	import cpu_pkg::*;

	logic grp_txa, grp_mov, grp_alu, grp_sic; // top 2-bit groups
	logic tmp04, tmp05, tmp06; // bits 3..2 helpers
	logic hi000, hi001, hi010, hi100, hi110; // mid field
	logic hi00x, hi01x, hi10x, hi11x, hi0x0;
	logic lo000, lo001, lo010, lo011, lo100, lo101, lo110, lo111; // low field
	logic lox00, lox01, lox11;
	logic mem_d, mem_s, is_hlt;
	logic cyc_2, cyc_3, cyc_4, cyc_5; // total machine cycles
	logic cycw2, cycw3, cycw4, cycw5; // cycle n is a write
	cyc_mask_t cyc_go, cyc_rw;

	assign grp_txa = ~i_opcode[7] & ~i_opcode[6]; // 00 transfer, inc/dec, misc
	assign grp_mov = ~i_opcode[7] & i_opcode[6]; // 01 mov + hlt
	assign grp_alu = i_opcode[7] & ~i_opcode[6]; // 10 alu with register
	assign grp_sic = i_opcode[7] & i_opcode[6]; // 11 stack, i/o, control

	assign tmp04 = ~i_opcode[3] & i_opcode[2];
	assign tmp05 = i_opcode[3] & ~i_opcode[2];
	assign tmp06 = i_opcode[3] & i_opcode[2];

	assign hi000 = ~i_opcode[5] & ~i_opcode[4] & ~i_opcode[3];
	assign hi001 = ~i_opcode[5] & ~i_opcode[4] & i_opcode[3];
	assign hi010 = ~i_opcode[5] & i_opcode[4] & ~i_opcode[3];
	assign hi100 = i_opcode[5] & ~i_opcode[4] & ~i_opcode[3];
	assign hi110 = i_opcode[5] & i_opcode[4] & ~i_opcode[3];
	assign hi00x = ~i_opcode[5] & ~i_opcode[4];
	assign hi01x = ~i_opcode[5] & i_opcode[4]; // in / out pair
	assign hi10x = i_opcode[5] & ~i_opcode[4];
	assign hi11x = i_opcode[5] & i_opcode[4];
	assign hi0x0 = ~i_opcode[5] & ~i_opcode[3];

	assign lo000 = ~i_opcode[2] & ~i_opcode[1] & ~i_opcode[0];
	assign lo001 = ~i_opcode[2] & ~i_opcode[1] & i_opcode[0];
	assign lo010 = ~i_opcode[2] & i_opcode[1] & ~i_opcode[0];
	assign lo011 = ~i_opcode[2] & i_opcode[1] & i_opcode[0];
	assign lo100 = i_opcode[2] & ~i_opcode[1] & ~i_opcode[0]; // 11xxx100 conditional call
	assign lo101 = i_opcode[2] & ~i_opcode[1] & i_opcode[0];
	assign lo110 = i_opcode[2] & i_opcode[1] & ~i_opcode[0];
	assign lo111 = i_opcode[2] & i_opcode[1] & i_opcode[0];
	assign lox00 = ~i_opcode[1] & ~i_opcode[0];
	assign lox01 = ~i_opcode[1] & i_opcode[0];
	assign lox11 = i_opcode[1] & i_opcode[0];

	assign mem_d = hi110; // dst is M
	assign mem_s = lo110; // src is M
	assign is_hlt = grp_mov & mem_d & mem_s; // 01110110

	assign cyc_2 =
		(grp_txa & lo110 & ~hi110) | // mvi r
		(grp_txa & lo010 & ~i_opcode[5]) | // ldax, stax
		(grp_sic & lo110) | // alu immediate
		(grp_mov & (mem_d ^ mem_s)) | // mov with one M
		(grp_alu & mem_s) | // alu M
		is_hlt;
	assign cyc_3 =
		(grp_sic & lo000) | // rccc, worst case
		(grp_sic & lo010) | // jccc
		(grp_sic & lo111) | // rst
		(grp_sic & lo101 & ~i_opcode[3]) | // push
		(grp_sic & lo001 & ~i_opcode[3]) | // pop
		(grp_sic & lo011 & hi000) | // jmp
		(grp_sic & lo001 & hi001) | // ret
		(grp_txa & lo001) | // lxi, dad
		(grp_txa & hi110 & i_opcode[2] & ~(i_opcode[1] & i_opcode[0])) | // inr/dcr/mvi M
		(grp_sic & lo011 & hi01x); // in, out
	assign cyc_4 = grp_txa & lo010 & hi11x; // sta, lda
	assign cyc_5 =
		(grp_sic & lo100) | // cccc
		(grp_sic & lo011 & hi100) | // xthl
		(grp_sic & lo101 & hi001) | // call
		(grp_txa & lo010 & hi10x); // shld, lhld

	assign cycw2 =
		(grp_sic & lo111) | // rst push high
		(grp_sic & lo101 & ~i_opcode[3]) | // push high
		(grp_txa & lo010 & hi0x0) | // stax
		(grp_mov & mem_d & ~mem_s); // mov M,r
	assign cycw3 =
		(grp_txa & hi110 & i_opcode[2] & ~(i_opcode[1] & i_opcode[0])) | // inr/dcr/mvi M
		(grp_sic & lo111) | // rst push low
		(grp_sic & lo101 & ~i_opcode[3]) | // push low
		(grp_sic & lo011 & hi010); // out
	assign cycw4 =
		(grp_sic & lo100) | // cccc
		(grp_sic & lo011 & hi100) | // xthl
		(grp_sic & lo101 & hi001) | // call
		(grp_txa & lo010 & hi100) | // shld
		(grp_txa & lo010 & hi110); // sta
	assign cycw5 =
		(grp_sic & lo100) | // cccc
		(grp_sic & lo011 & hi100) | // xthl
		(grp_sic & lo101 & hi001) | // call
		(grp_txa & lo010 & hi100); // shld

	always_comb begin
		if (cyc_2) cyc_go = 4'b0001; // first match wins
		else if (cyc_3) cyc_go = 4'b0011;
		else if (cyc_4) cyc_go = 4'b0111;
		else if (cyc_5) cyc_go = 4'b1111;
		else cyc_go = 4'b0000; // single cycle
		cyc_rw = {cycw5, cycw4, cycw3, cycw2};
	end

	always_comb begin
		o_info = '0;
		o_info.go6 = (grp_txa & ~i_opcode[2] & lox11) | // inx, dcx
			(grp_sic & i_opcode[2] & lox11) | // rst
			(grp_sic & lox00) | // rccc, cccc
			(grp_sic & tmp04 & lox01) | // push
			(grp_sic & i_opcode[5] & tmp05 & lox01) | // pchl, sphl
			(grp_sic & hi00x & tmp06 & lox01); // call
		o_info.dad = grp_txa & lo001 & i_opcode[3];
		o_info.hlt = is_hlt;
		o_info.dio = grp_sic & lo011 & hi01x;
		o_info.cyc_go = cyc_go;
		o_info.cyc_rw = cyc_rw;
		o_info.cond = 1'b0; // filled in by reg_bank
	end

endmodule

`default_nettype wire

// File: reg_bank.sv
`timescale 1ns/10ps
`include "cpu_params.svh"
`default_nettype none

module reg_bank (
	input logic clk,
	input logic i_rst_n,
	input logic i_enb_c, // latch instruction
	input logic i_enb_d, // latch temp
	input logic i_enbpc, // pc + 1
	input logic i_enb_r, // read port enable
	input logic i_enb_w, // write back
	input cpu_pkg::data_t i_bus_d,
	input cpu_pkg::data_t i_alu_res,
	input cpu_pkg::flags_t i_alu_flags,
	input cpu_pkg::inst_info_t i_info, // from decoder
	output cpu_pkg::data_t o_opcode,
	output cpu_pkg::data_t o_op1,
	output cpu_pkg::data_t o_op2,
	output cpu_pkg::flags_t o_flags,
	output cpu_pkg::inst_info_t o_inst_info,
	output cpu_pkg::addr_t o_pc,
	output cpu_pkg::data_t o_rd_data
);
	import cpu_pkg::*;

	data_t inst_q, temp_q; // instruction and temp latches
	data_t regs [8]; // B C D E H L F A
	addr_t pc_q, pc_inc;
	reg_sel_t dst_sel, src_sel;
	logic is_alu, is_mov, is_hlt, mem_s;
	data_t src_d, wr_d, flag_d;
	logic [7:0] wr_en; // per register write strobe
	logic cond;

	always_ff @(posedge clk) begin
		if (i_enb_c) inst_q <= i_bus_d;
		if (i_enb_d) temp_q <= i_bus_d; // immediate / memory operand
	end

	assign dst_sel = inst_q[5:3];
	assign src_sel = inst_q[2:0];
	assign is_alu = inst_q[7] & ~inst_q[6]; // 10xxxxxx
	assign is_mov = ~inst_q[7] & inst_q[6]; // 01xxxxxx
	assign mem_s = (src_sel == 3'b110); // src is M, use temp
	assign is_hlt = is_mov & mem_s & (dst_sel == 3'b110);

	assign src_d = mem_s ? temp_q : regs[src_sel];
	assign wr_d = is_alu ? i_alu_res : src_d; // alu result or mov data
	assign flag_d = data_t'(i_alu_flags) & `FLAG_MASK;

	// alu writes A and F, mov writes dst; F only via alu
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			wr_en[i] = i_enb_w & ((is_alu & (reg_sel_t'(i) == `REG_A)) |
				(is_mov & ~is_hlt & (dst_sel == reg_sel_t'(i))));
		end
		wr_en[`REG_F] = i_enb_w & is_alu;
	end

	for (genvar g = 0; g < 8; g++) begin : g_reg
		if (g == `REG_F) begin : g_flag
			always_ff @(posedge clk) begin
				if (!i_rst_n) regs[g] <= '0; // flags start cleared
				else if (wr_en[g]) regs[g] <= flag_d;
			end
		end else begin : g_data
			always_ff @(posedge clk) begin
				if (wr_en[g]) regs[g] <= wr_d;
			end
		end
	end

	// condition code from bits 5..3
	always_comb begin
		case (dst_sel)
			3'b000: cond = ~regs[`REG_F][`FLAGBIT_Z]; // nz
			3'b001: cond = regs[`REG_F][`FLAGBIT_Z]; // z
			3'b010: cond = ~regs[`REG_F][`FLAGBIT_C]; // nc
			3'b011: cond = regs[`REG_F][`FLAGBIT_C]; // c
			3'b100: cond = ~regs[`REG_F][`FLAGBIT_P]; // po
			3'b101: cond = regs[`REG_F][`FLAGBIT_P]; // pe
			3'b110: cond = ~regs[`REG_F][`FLAGBIT_S]; // p
			default: cond = regs[`REG_F][`FLAGBIT_S]; // m
		endcase
	end

	always_comb begin
		o_inst_info = i_info;
		o_inst_info.cond = cond;
	end

	assign pc_inc = pc_q + 16'd1; // wraps at ffff

	always_ff @(posedge clk) begin
		if (!i_rst_n) pc_q <= '0;
		else if (i_enbpc) pc_q <= pc_inc;
	end

	assign o_pc = pc_q;
	assign o_opcode = inst_q;
	assign o_op1 = regs[`REG_A];
	assign o_op2 = src_d;
	assign o_flags = flags_t'(regs[`REG_F]);
	assign o_rd_data = i_enb_r ? regs[src_sel] : '0; // 110 reads F here

endmodule

`default_nettype wire

// File: src.f
+incdir+.
cpu_pkg.sv
inst_decode.sv
alu8.sv
reg_bank.sv
alureg.sv
alureg_tb.sv
